/* logic/regfile_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared constants for the banked 1024x32 register file.
// Only the four wr0_en patterns below are legal; anything else is
// treated as no write.
//////////////////////////////////////////////////////////////////////

package regfile_pkg;

   //////////////////////////////////////////////////////////////////////
   // Storage geometry
   //////////////////////////////////////////////////////////////////////

   // Banks picked by the low two word-address bits
   localparam int BANKS = 4;

   // One register word
   localparam int WORD_BITS = 32;

   //////////////////////////////////////////////////////////////////////
   // Wide write enable patterns
   //////////////////////////////////////////////////////////////////////

   // No write this cycle
   localparam logic [3:0] EN_NONE = 4'b0000;

   // Single word at wr0_addr
   localparam logic [3:0] EN_ONE = 4'b0001;

   // Two consecutive words
   localparam logic [3:0] EN_TWO = 4'b0011;

   // Four consecutive words
   localparam logic [3:0] EN_FOUR = 4'b1111;

endpackage

/* logic/regfile_bank.sv */
//////////////////////////////////////////////////////////////////////
// One storage bank, three read ports and one write port.
// Reads have one cycle of latency through registered rows, so a
// write at an edge is visible to reads registered at the same edge.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module regfile_bank #(
   parameter int ADDR_BITS = 10,
   localparam int ROW_BITS = ADDR_BITS - 2
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [ROW_BITS-1:0]               rd0_row,
   input  logic [ROW_BITS-1:0]               rd1_row,
   input  logic [ROW_BITS-1:0]               rd2_row,
   output logic [regfile_pkg::WORD_BITS-1:0] rd0_word,
   output logic [regfile_pkg::WORD_BITS-1:0] rd1_word,
   output logic [regfile_pkg::WORD_BITS-1:0] rd2_word,
   input  logic [ROW_BITS-1:0]               wr_row,
   input  logic                              wr_en,
   input  logic [regfile_pkg::WORD_BITS-1:0] wr_word
);

   logic [regfile_pkg::WORD_BITS-1:0] mem [0:(1 << ROW_BITS)-1];

   logic [ROW_BITS-1:0] rd0_row_q;
   logic [ROW_BITS-1:0] rd1_row_q;
   logic [ROW_BITS-1:0] rd2_row_q;

   // Read row registers
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd0_row_q <= '0;
         rd1_row_q <= '0;
         rd2_row_q <= '0;
      end
      else
      begin
         rd0_row_q <= rd0_row;
         rd1_row_q <= rd1_row;
         rd2_row_q <= rd2_row;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_row] <= wr_word;
      end
   end

   // Array read after the row register gives write-through
   assign rd0_word = mem[rd0_row_q];
   assign rd1_word = mem[rd1_row_q];
   assign rd2_word = mem[rd2_row_q];

endmodule

/* logic/wide_write_spread.sv */
//////////////////////////////////////////////////////////////////////
// Spreads a 1, 2 or 4 word write across the four banks.
// Purely combinational. Addresses past the last word wrap to row 0.
// An illegal wr0_en pattern disables every bank.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wide_write_spread #(
   parameter int ADDR_BITS = 10,
   localparam int ROW_BITS = ADDR_BITS - 2
) (
   input  logic [ADDR_BITS-1:0]                                   wr0_addr,
   input  logic [3:0]                                             wr0_en,
   input  logic [regfile_pkg::BANKS*regfile_pkg::WORD_BITS-1:0]   wr0_data,
   output logic [regfile_pkg::BANKS-1:0][ROW_BITS-1:0]            bank_wr_row,
   output logic [regfile_pkg::BANKS-1:0]                          bank_wr_en,
   output logic [regfile_pkg::BANKS-1:0][regfile_pkg::WORD_BITS-1:0] bank_wr_word
);

   logic [1:0] offset;
   logic [regfile_pkg::BANKS-1:0] width_mask;
   logic [2*regfile_pkg::BANKS-1:0] mask_rot;

   assign offset = wr0_addr[1:0];

   //////////////////////////////////////////////////////////////////////
   // Address and data lanes
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int b = 0; b < regfile_pkg::BANKS; b++)
      begin
         logic [1:0] lane;
         logic [ADDR_BITS-1:0] lane_addr;

         // Lane whose address lands in bank b
         lane = 2'(b) - offset;
         lane_addr = wr0_addr + ADDR_BITS'(lane);
         bank_wr_row[b] = lane_addr[ADDR_BITS-1:2];
         bank_wr_word[b] = wr0_data[lane*regfile_pkg::WORD_BITS +: regfile_pkg::WORD_BITS];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Bank enables
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (wr0_en)
         regfile_pkg::EN_ONE,
         regfile_pkg::EN_TWO,
         regfile_pkg::EN_FOUR:
         begin
            width_mask = wr0_en;
         end
         default:
         begin
            width_mask = regfile_pkg::EN_NONE;
         end
      endcase
   end

   // Rotate left by the word offset, wrapping bank 3 into bank 0
   assign mask_rot = {width_mask, width_mask} << offset;
   assign bank_wr_en = mask_rot[2*regfile_pkg::BANKS-1:regfile_pkg::BANKS];

   // Caller must only ever drive one of the legal patterns
   always_comb
   begin
      if (!$isunknown(wr0_en))
      begin
         legal_en: assert (wr0_en == regfile_pkg::EN_NONE ||
                           wr0_en == regfile_pkg::EN_ONE ||
                           wr0_en == regfile_pkg::EN_TWO ||
                           wr0_en == regfile_pkg::EN_FOUR)
            else $error("wide_write_spread: illegal wr0_en %b", wr0_en);
      end
   end

endmodule

/* logic/wide_read_gather.sv */
//////////////////////////////////////////////////////////////////////
// Wide read port routing. Rotates rows out to the banks and puts the
// returned words back in address order one cycle later.
// rd0_addr must be known whenever reset is low.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wide_read_gather #(
   parameter int ADDR_BITS = 10,
   localparam int ROW_BITS = ADDR_BITS - 2
) (
   input  logic                                                      clk,
   input  logic                                                      reset,
   input  logic [ADDR_BITS-1:0]                                      rd0_addr,
   output logic [regfile_pkg::BANKS-1:0][ROW_BITS-1:0]               bank_rd_row,
   input  logic [regfile_pkg::BANKS-1:0][regfile_pkg::WORD_BITS-1:0] bank_rd_word,
   output logic [regfile_pkg::BANKS*regfile_pkg::WORD_BITS-1:0]      rd0_data
);

   logic [1:0] offset;
   logic [1:0] offset_q;

   assign offset = rd0_addr[1:0];

   // Same rotation as the write side
   always_comb
   begin
      for (int b = 0; b < regfile_pkg::BANKS; b++)
      begin
         logic [1:0] lane;
         logic [ADDR_BITS-1:0] lane_addr;

         lane = 2'(b) - offset;
         lane_addr = rd0_addr + ADDR_BITS'(lane);
         bank_rd_row[b] = lane_addr[ADDR_BITS-1:2];
      end
   end

   // Offset follows the bank row register
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         offset_q <= 2'b00;
      end
      else
      begin
         offset_q <= offset;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Return path, lane k from bank (offset + k) mod 4
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int k = 0; k < regfile_pkg::BANKS; k++)
      begin
         rd0_data[k*regfile_pkg::WORD_BITS +: regfile_pkg::WORD_BITS] =
            bank_rd_word[2'(k) + offset_q];
      end
   end

   // An X here would corrupt all four bank rows at once
   addr_known: assert property (@(posedge clk) disable iff (reset)
                                !$isunknown(rd0_addr))
      else $error("wide_read_gather: rd0_addr has unknown bits");

endmodule

/* logic/narrow_read_select.sv */
//////////////////////////////////////////////////////////////////////
// Single word read port. Every bank reads the same row; the bank
// bits are registered to line up with the bank's row register.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module narrow_read_select (
   input  logic                                                      clk,
   input  logic                                                      reset,
   input  logic [1:0]                                                bank_sel,
   input  logic [regfile_pkg::BANKS-1:0][regfile_pkg::WORD_BITS-1:0] bank_word,
   output logic [regfile_pkg::WORD_BITS-1:0]                         rd_data
);

   logic [1:0] bank_sel_q;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bank_sel_q <= 2'b00;
      end
      else
      begin
         bank_sel_q <= bank_sel;
      end
   end

   // Word from the bank holding the address
   assign rd_data = bank_word[bank_sel_q];

endmodule

/* logic/regfile_1024x32b_3r_1w.sv */
//////////////////////////////////////////////////////////////////////
// Banked register file, one wide and two narrow read ports, one wide
// write port. Reads return one cycle after the address and see a
// same-cycle write. No arbitration beyond that.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module regfile_1024x32b_3r_1w #(
   parameter int ADDR_BITS = 10
) (
   input  logic                                                 clk,
   input  logic                                                 reset,
   input  logic [ADDR_BITS-1:0]                                 rd0_addr,
   input  logic [ADDR_BITS-1:0]                                 rd1_addr,
   input  logic [ADDR_BITS-1:0]                                 rd2_addr,
   output logic [regfile_pkg::BANKS*regfile_pkg::WORD_BITS-1:0] rd0_data,
   output logic [regfile_pkg::WORD_BITS-1:0]                    rd1_data,
   output logic [regfile_pkg::WORD_BITS-1:0]                    rd2_data,
   input  logic [ADDR_BITS-1:0]                                 wr0_addr,
   input  logic [3:0]                                           wr0_en,
   input  logic [regfile_pkg::BANKS*regfile_pkg::WORD_BITS-1:0] wr0_data
);

   localparam int ROW_BITS = ADDR_BITS - 2;

   // Per-bank write side
   logic [regfile_pkg::BANKS-1:0][ROW_BITS-1:0]               wr_row;
   logic [regfile_pkg::BANKS-1:0]                             wr_en;
   logic [regfile_pkg::BANKS-1:0][regfile_pkg::WORD_BITS-1:0] wr_word;

   // Per-bank read side
   logic [regfile_pkg::BANKS-1:0][ROW_BITS-1:0]               rd0_row;
   logic [regfile_pkg::BANKS-1:0][regfile_pkg::WORD_BITS-1:0] rd0_word;
   logic [regfile_pkg::BANKS-1:0][regfile_pkg::WORD_BITS-1:0] rd1_word;
   logic [regfile_pkg::BANKS-1:0][regfile_pkg::WORD_BITS-1:0] rd2_word;

   wide_write_spread #(.ADDR_BITS(ADDR_BITS)) u_write_spread (
      .wr0_addr     (wr0_addr),
      .wr0_en       (wr0_en),
      .wr0_data     (wr0_data),
      .bank_wr_row  (wr_row),
      .bank_wr_en   (wr_en),
      .bank_wr_word (wr_word)
   );

   wide_read_gather #(.ADDR_BITS(ADDR_BITS)) u_read_gather (
      .clk          (clk),
      .reset        (reset),
      .rd0_addr     (rd0_addr),
      .bank_rd_row  (rd0_row),
      .bank_rd_word (rd0_word),
      .rd0_data     (rd0_data)
   );

   //////////////////////////////////////////////////////////////////////
   // Storage banks
   //////////////////////////////////////////////////////////////////////

   for (genvar b = 0; b < regfile_pkg::BANKS; b++)
   begin : g_bank
      regfile_bank #(.ADDR_BITS(ADDR_BITS)) u_bank (
         .clk      (clk),
         .reset    (reset),
         .rd0_row  (rd0_row[b]),
         .rd1_row  (rd1_addr[ADDR_BITS-1:2]),
         .rd2_row  (rd2_addr[ADDR_BITS-1:2]),
         .rd0_word (rd0_word[b]),
         .rd1_word (rd1_word[b]),
         .rd2_word (rd2_word[b]),
         .wr_row   (wr_row[b]),
         .wr_en    (wr_en[b]),
         .wr_word  (wr_word[b])
      );
   end

   // Narrow ports
   narrow_read_select u_rd1_select (
      .clk       (clk),
      .reset     (reset),
      .bank_sel  (rd1_addr[1:0]),
      .bank_word (rd1_word),
      .rd_data   (rd1_data)
   );

   narrow_read_select u_rd2_select (
      .clk       (clk),
      .reset     (reset),
      .bank_sel  (rd2_addr[1:0]),
      .bank_word (rd2_word),
      .rd_data   (rd2_data)
   );

endmodule

/* include/regfile_tb_model.svh */
//////////////////////////////////////////////////////////////////////
// Reference model of the register file, included inside the
// testbench module. Contents start undefined like the DUT storage.
//////////////////////////////////////////////////////////////////////

`ifndef REGFILE_TB_MODEL_SVH
`define REGFILE_TB_MODEL_SVH

localparam int MODEL_WORDS = 1024;

logic [regfile_pkg::WORD_BITS-1:0] model_mem [0:MODEL_WORDS-1];

// Words written for a wr0_en pattern, 0 if illegal
function automatic int model_width(input logic [3:0] en);
   case (en)
      regfile_pkg::EN_ONE:  return 1;
      regfile_pkg::EN_TWO:  return 2;
      regfile_pkg::EN_FOUR: return 4;
      default:              return 0;
   endcase
endfunction

// Wide write with wrap past the last word
function automatic void model_write(input int addr,
                                    input logic [3:0] en,
                                    input logic [4*regfile_pkg::WORD_BITS-1:0] data);
   int width;

   width = model_width(en);
   for (int k = 0; k < width; k++)
   begin
      model_mem[(addr + k) % MODEL_WORDS] =
         data[k*regfile_pkg::WORD_BITS +: regfile_pkg::WORD_BITS];
   end
endfunction

// Four words starting at addr, lane k holds addr + k
function automatic logic [4*regfile_pkg::WORD_BITS-1:0] model_read_wide(input int addr);
   logic [4*regfile_pkg::WORD_BITS-1:0] result;

   for (int k = 0; k < 4; k++)
   begin
      result[k*regfile_pkg::WORD_BITS +: regfile_pkg::WORD_BITS] =
         model_mem[(addr + k) % MODEL_WORDS];
   end
   return result;
endfunction

// Single word read for the narrow ports
function automatic logic [regfile_pkg::WORD_BITS-1:0] model_read_word(input int addr);
   return model_mem[addr % MODEL_WORDS];
endfunction

`endif

/* test/regfile_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the banked register file. Random traffic from a fixed
// seed is checked against a word array model, one cycle after issue.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module regfile_tb;

   localparam int ADDR_BITS = 10;
   localparam int WORD_BITS = regfile_pkg::WORD_BITS;

   logic                   clk;
   logic                   reset;
   logic [ADDR_BITS-1:0]   rd0_addr;
   logic [ADDR_BITS-1:0]   rd1_addr;
   logic [ADDR_BITS-1:0]   rd2_addr;
   logic [4*WORD_BITS-1:0] rd0_data;
   logic [WORD_BITS-1:0]   rd1_data;
   logic [WORD_BITS-1:0]   rd2_data;
   logic [ADDR_BITS-1:0]   wr0_addr;
   logic [3:0]             wr0_en;
   logic [4*WORD_BITS-1:0] wr0_data;

   `include "regfile_tb_model.svh"

   // Reads issued at the last edge and checked before the next one
   int                     pend_rd0_width;
   int                     pend_rd0_addr;
   bit                     pend_narrow;
   int                     pend_rd1_addr;
   int                     pend_rd2_addr;
   string                  pend_test;
   logic [4*WORD_BITS-1:0] exp_rd0;
   logic [WORD_BITS-1:0]   exp_rd1;
   logic [WORD_BITS-1:0]   exp_rd2;

   int rd0_errors;
   int narrow_errors;
   int timeout_errors;

   regfile_1024x32b_3r_1w #(.ADDR_BITS(ADDR_BITS)) dut (
      .clk      (clk),
      .reset    (reset),
      .rd0_addr (rd0_addr),
      .rd1_addr (rd1_addr),
      .rd2_addr (rd2_addr),
      .rd0_data (rd0_data),
      .rd1_data (rd1_data),
      .rd2_data (rd2_data),
      .wr0_addr (wr0_addr),
      .wr0_en   (wr0_en),
      .wr0_data (wr0_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [4*WORD_BITS-1:0] random_data();
      return {$urandom(), $urandom(), $urandom(), $urandom()};
   endfunction

   // Biased toward the top words so wide accesses wrap
   function automatic int random_addr();
      if ($urandom_range(0, 7) == 0)
      begin
         return MODEL_WORDS - int'($urandom_range(1, 3));
      end
      return int'($urandom_range(0, MODEL_WORDS - 1));
   endfunction

   function automatic logic [3:0] random_en();
      case ($urandom_range(0, 2))
         0:       return regfile_pkg::EN_ONE;
         1:       return regfile_pkg::EN_TWO;
         default: return regfile_pkg::EN_FOUR;
      endcase
   endfunction

   task automatic check_pending();
      logic [WORD_BITS-1:0] exp_word;
      logic [WORD_BITS-1:0] act_word;

      for (int k = 0; k < pend_rd0_width; k++)
      begin
         exp_word = exp_rd0[k*WORD_BITS +: WORD_BITS];
         act_word = rd0_data[k*WORD_BITS +: WORD_BITS];
         rd0_lane_ok: assert (act_word === exp_word)
         else
         begin
            rd0_errors++;
            $display("FAILED %s rd0 lane %0d addr %0d expected %h actual %h", pend_test,
                     k, (pend_rd0_addr + k) % MODEL_WORDS, exp_word, act_word);
         end
      end
      if (pend_narrow)
      begin
         rd1_ok: assert (rd1_data === exp_rd1)
         else
         begin
            narrow_errors++;
            $display("FAILED %s rd1 addr %0d expected %h actual %h", pend_test,
                     pend_rd1_addr, exp_rd1, rd1_data);
         end
         rd2_ok: assert (rd2_data === exp_rd2)
         else
         begin
            narrow_errors++;
            $display("FAILED %s rd2 addr %0d expected %h actual %h", pend_test,
                     pend_rd2_addr, exp_rd2, rd2_data);
         end
      end
   endtask

   // Drive one cycle and check the previous reads before the next edge
   task automatic run_cycle(input string test, input int r0_addr, input int r0_width,
                            input int r1_addr, input int r2_addr, input bit narrow_chk,
                            input int w_addr, input logic [3:0] w_en,
                            input logic [4*WORD_BITS-1:0] w_data);
      @(negedge clk);
      rd0_addr = ADDR_BITS'(r0_addr);
      rd1_addr = ADDR_BITS'(r1_addr);
      rd2_addr = ADDR_BITS'(r2_addr);
      wr0_addr = ADDR_BITS'(w_addr);
      wr0_en   = w_en;
      wr0_data = w_data;
      // Previous results must hold after the addresses move
      #1;
      check_pending();
      @(posedge clk);
      // Write first so reads at this edge see it
      model_write(w_addr, w_en, w_data);
      exp_rd0        = model_read_wide(r0_addr);
      exp_rd1        = model_read_word(r1_addr);
      exp_rd2        = model_read_word(r2_addr);
      pend_rd0_width = r0_width;
      pend_rd0_addr  = r0_addr;
      pend_narrow    = narrow_chk;
      pend_rd1_addr  = r1_addr;
      pend_rd2_addr  = r2_addr;
      pend_test      = test;
   endtask

   task automatic report_and_finish();
      $display("rd0 errors %0d, narrow errors %0d, timeouts %0d",
               rd0_errors, narrow_errors, timeout_errors);
      if (rd0_errors + narrow_errors + timeout_errors == 0)
      begin
         $display("ALL CHECKS PASSED");
      end
      else
      begin
         $display("CHECKS FAILED");
      end
      $finish;
   endtask

   // Words 0 to 3 must read back known once the fill is done
   task automatic wait_rd0_known(input int limit);
      int n;

      n = 0;
      run_cycle("fill_wait", 0, 0, 0, 0, 1'b0, 0, regfile_pkg::EN_NONE, '0);
      @(negedge clk);
      while ($isunknown(rd0_data) && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= limit)
      begin
         timeout_errors++;
         $display("Timeout: rd0_data still unknown %0d cycles after the fill", limit);
         report_and_finish();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      int a;
      logic [3:0] en;

      reset          = 1'b1;
      rd0_addr       = '0;
      rd1_addr       = '0;
      rd2_addr       = '0;
      wr0_addr       = '0;
      wr0_en         = regfile_pkg::EN_NONE;
      wr0_data       = '0;
      pend_rd0_width = 0;
      pend_narrow    = 1'b0;
      rd0_errors     = 0;
      narrow_errors  = 0;
      timeout_errors = 0;
      void'($urandom(32'h4fef_29b8));

      for (int i = 0; i < 8; i++)
      begin
         @(posedge clk);
      end
      @(negedge clk);
      reset = 1'b0;

      // Fill and aligned readback
      for (int i = 0; i < MODEL_WORDS; i += 4)
      begin
         run_cycle("fill", 0, 0, 0, 0, 1'b0, i, regfile_pkg::EN_FOUR, random_data());
      end
      wait_rd0_known(16);
      for (int i = 0; i < MODEL_WORDS; i += 4)
      begin
         run_cycle("fill_read", i, 4, 0, 0, 1'b0, 0, regfile_pkg::EN_NONE, '0);
      end

      // Unaligned wide traffic with wrap
      for (int i = 0; i < 400; i++)
      begin
         run_cycle("unaligned", random_addr(), model_width(random_en()), 0, 0, 1'b0,
                   random_addr(), random_en(), random_data());
      end

      // Narrow ports back to back
      for (int i = 0; i < 300; i++)
      begin
         run_cycle("narrow", random_addr(), 4, random_addr(), random_addr(), 1'b1,
                   random_addr(), random_en(), random_data());
      end

      // Same-cycle write and overlapping reads
      for (int i = 0; i < 100; i++)
      begin
         a  = random_addr();
         en = random_en();
         run_cycle("write_through", a, model_width(en), a,
                   (a + int'($urandom_range(0, 3))) % MODEL_WORDS, 1'b1,
                   a, en, random_data());
      end

      // Disabled writes leave memory alone
      for (int i = 0; i < 100; i++)
      begin
         a = random_addr();
         run_cycle("no_write", a, 4, a, (a + 1) % MODEL_WORDS, 1'b1,
                   a, regfile_pkg::EN_NONE, random_data());
      end
      for (int i = 0; i < MODEL_WORDS; i += 4)
      begin
         run_cycle("no_write_read", i, 4, i + 1, i + 2, 1'b1, 0,
                   regfile_pkg::EN_NONE, '0);
      end

      // Flush the last pending check
      run_cycle("flush", 0, 0, 0, 0, 1'b0, 0, regfile_pkg::EN_NONE, '0);
      report_and_finish();
   end

endmodule

/* build.f */
logic/regfile_pkg.sv
logic/regfile_bank.sv
logic/wide_write_spread.sv
logic/wide_read_gather.sv
logic/narrow_read_select.sv
logic/regfile_1024x32b_3r_1w.sv
+incdir+include
test/regfile_tb.sv

/* Makefile */
# Verilator flow for the banked register file

TOOL       = verilator
TOP        = regfile_tb
FILE_LIST  = build.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing -Wno-fatal
SIM_FLAGS  = --binary --timing -Wno-fatal --Mdir $(OBJ_DIR)
PASS_TEXT  = ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
